// File: rv_mini_pkg.sv
`default_nettype none

package rv_mini_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;
    localparam int CMD_W      = 4;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    localparam logic [6:0] OPC_OP_IMM = 7'b00100_11;
    localparam logic [6:0] OPC_LUI    = 7'b01101_11;
    localparam logic [6:0] OPC_AUIPC  = 7'b00101_11;
    localparam logic [6:0] OPC_SYSTEM = 7'b11100_11;

    localparam logic [2:0]  F3_ADDI    = 3'b000;
    localparam logic [11:0] F12_EBREAK = 12'h001; // ecall has zero here.

    // Fetch unit states.
    localparam logic [1:0] ST_REQ  = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1;
    localparam logic [1:0] ST_HALT = 2'd2;

    typedef enum logic [CMD_W-1:0] {
        CMD_NOP  = 4'd0,
        CMD_ADD  = 4'd1,
        CMD_EQU  = 4'd2, // Pass src1 through.
        CMD_HALT = 4'd3
    } cmd_e;

    typedef union packed {
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i_fmt;
        struct packed {
            logic [19:0]           imm20;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } u_fmt;
    } inst_u;

endpackage

`default_nettype wire

// File: rv_mini_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_if import rv_mini_pkg::*; ();

    logic            valid; // One pulse per fetched word.
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;

    modport source (output valid, inst, pc);
    modport sink   (input valid, inst, pc);

endinterface

interface issue_if import rv_mini_pkg::*; ();

    logic                  valid; // One pulse per decoded word.
    cmd_e                  command;
    logic [XLEN-1:0]       src1;
    logic [XLEN-1:0]       src2;
    logic [REG_ADDR_W-1:0] des;    // Zero when nothing is written.

    modport source (output valid, command, src1, src2, des);
    modport sink   (input valid, command, src1, src2, des);

endinterface

`default_nettype wire

// File: rv_mini_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mini_regfile import rv_mini_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // The execute stage filters x0 before it raises we.
    assert property (@(posedge clk) disable iff (!arst_n) !(we && (waddr == '0)))
        else $error("write to x0 attempted");

endmodule

`default_nettype wire

// File: rv_mini_ifu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mini_ifu import rv_mini_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic [XLEN-1:0] wb_adr,
    input  logic [XLEN-1:0] wb_dat_r,
    input  logic            wb_ack,
    input  logic            retire,
    input  logic            halt,
    fetch_if.source         fetch
);

    logic [1:0]      state_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] inst_q;
    logic            cyc_q;
    logic            valid_q;
    logic            take;

    assign take = (state_q == ST_REQ) && cyc_q && wb_ack; // Word accepted on this edge.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_REQ;
            pc_q    <= RESET_PC;
            cyc_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= take;
            case (state_q)
                ST_REQ: begin
                    if (take) begin
                        cyc_q   <= 1'b0;
                        state_q <= ST_WAIT;
                    end else begin
                        cyc_q <= 1'b1; // Opens the first read after reset.
                    end
                end
                ST_WAIT: begin
                    if (retire && halt) begin
                        state_q <= ST_HALT;
                    end else if (retire) begin
                        pc_q    <= pc_q + XLEN'(4);
                        cyc_q   <= 1'b1;
                        state_q <= ST_REQ;
                    end
                end
                default: begin
                    cyc_q <= 1'b0; // Bus stays idle once halted.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            inst_q <= wb_dat_r;
        end
    end

    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q;
    assign wb_adr = pc_q;

    assign fetch.valid = valid_q;
    assign fetch.inst  = inst_q;
    assign fetch.pc    = pc_q;

    assert property (@(posedge clk) disable iff (!arst_n) wb_stb |-> wb_cyc)
        else $error("stb high without cyc");

    // A pending request keeps its address until the slave acks.
    assert property (@(posedge clk) disable iff (!arst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else $error("adr changed while waiting for ack");

endmodule

`default_nettype wire

// File: rv_mini_idu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mini_idu import rv_mini_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    fetch_if.sink                 fetch,
    output logic [REG_ADDR_W-1:0] raddr1,
    output logic [REG_ADDR_W-1:0] raddr2,
    input  logic [XLEN-1:0]       rdata1,
    input  logic [XLEN-1:0]       rdata2,
    issue_if.source               issue
);

    inst_u                 word;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_u;
    cmd_e                  cmd_d;
    logic [XLEN-1:0]       src1_d;
    logic [XLEN-1:0]       src2_d;
    logic [REG_ADDR_W-1:0] des_d;
    logic                  is_ebreak;

    logic                  valid_q;
    cmd_e                  cmd_q;
    logic [XLEN-1:0]       src1_q;
    logic [XLEN-1:0]       src2_q;
    logic [REG_ADDR_W-1:0] des_q;

    assign word = fetch.inst;

    assign raddr1 = word.i_fmt.rs1;
    assign raddr2 = word.i_fmt.imm12[REG_ADDR_W-1:0]; // rs2 field of R and S formats.

    assign imm_i = {{20{word.i_fmt.imm12[11]}}, word.i_fmt.imm12};
    assign imm_u = {word.u_fmt.imm20, 12'b0};

    assign is_ebreak = (word.i_fmt.imm12 == F12_EBREAK) && (word.i_fmt.rs1 == '0)
                       && (word.i_fmt.funct3 == '0) && (word.i_fmt.rd == '0);

    always_comb begin
        cmd_d  = CMD_NOP;
        src1_d = '0;
        src2_d = '0;
        des_d  = '0;
        case (word.i_fmt.opcode)
            OPC_OP_IMM: begin
                if (word.i_fmt.funct3 == F3_ADDI) begin
                    cmd_d  = CMD_ADD;
                    src1_d = imm_i;
                    src2_d = rdata1;
                    des_d  = word.i_fmt.rd;
                end
            end
            OPC_LUI: begin
                cmd_d  = CMD_EQU;
                src1_d = imm_u;
                des_d  = word.u_fmt.rd;
            end
            OPC_AUIPC: begin
                cmd_d  = CMD_ADD;
                src1_d = fetch.pc;
                src2_d = imm_u;
                des_d  = word.u_fmt.rd;
            end
            OPC_SYSTEM: begin
                if (is_ebreak) begin
                    cmd_d = CMD_HALT;
                end
            end
            default: begin
                cmd_d = CMD_NOP;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.valid) begin
            cmd_q  <= cmd_d;
            src1_q <= src1_d;
            src2_q <= src2_d;
            des_q  <= des_d;
        end
    end

    assign issue.valid   = valid_q;
    assign issue.command = cmd_q;
    assign issue.src1    = src1_q;
    assign issue.src2    = src2_q;
    assign issue.des     = des_q;

    assert property (@(posedge clk) disable iff (!arst_n)
        (issue.valid && issue.command == CMD_HALT) |-> (issue.des == '0))
        else $error("halt issued with a destination register");

endmodule

`default_nettype wire

// File: rv_mini_exu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mini_exu import rv_mini_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    issue_if.sink                 issue,
    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic [XLEN-1:0]       rf_wdata,
    output logic                  retire,
    output logic                  halted,
    output logic                  ret_valid,
    output logic [REG_ADDR_W-1:0] ret_rd,
    output logic [XLEN-1:0]       ret_data
);

    logic [XLEN-1:0]       result;
    logic                  writes;
    logic                  ret_q;
    logic                  we_q;
    logic                  halted_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [XLEN-1:0]       res_q;

    always_comb begin
        case (issue.command)
            CMD_ADD: result = issue.src1 + issue.src2;
            CMD_EQU: result = issue.src1;
            default: result = '0;
        endcase
    end

    assign writes = issue.valid && (issue.des != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ret_q    <= 1'b0;
            we_q     <= 1'b0;
            halted_q <= 1'b0;
        end else begin
            ret_q <= issue.valid;
            we_q  <= writes;
            if (issue.valid && issue.command == CMD_HALT) begin
                halted_q <= 1'b1; // Sticky until reset.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            res_q <= result;
            rd_q  <= issue.des;
        end
    end

    assign rf_we     = we_q;
    assign rf_waddr  = rd_q;
    assign rf_wdata  = res_q;
    assign retire    = ret_q;
    assign ret_valid = ret_q;
    assign ret_rd    = rd_q;
    assign ret_data  = res_q;
    assign halted    = halted_q;

    // One instruction in flight, so nothing new issues while retiring.
    assert property (@(posedge clk) disable iff (!arst_n)
        issue.valid |=> (retire && !issue.valid))
        else $error("retire did not follow issue by one cycle");

endmodule

`default_nettype wire

// File: rv_mini_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mini_core import rv_mini_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [XLEN-1:0]       wb_adr,
    input  logic [XLEN-1:0]       wb_dat_r,
    input  logic                  wb_ack,
    output logic                  ret_valid,
    output logic [REG_ADDR_W-1:0] ret_rd,
    output logic [XLEN-1:0]       ret_data,
    output logic                  halted
);

    logic                  retire;
    logic [REG_ADDR_W-1:0] raddr1;
    logic [REG_ADDR_W-1:0] raddr2;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    fetch_if fetch_bus ();
    issue_if issue_bus ();

    assign wb_we = 1'b0; // Instruction port only reads.

    rv_mini_ifu u_ifu (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .retire   (retire),
        .halt     (halted),
        .fetch    (fetch_bus.source)
    );

    rv_mini_idu u_idu (
        .clk    (clk),
        .arst_n (arst_n),
        .fetch  (fetch_bus.sink),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .issue  (issue_bus.source)
    );

    rv_mini_exu u_exu (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue     (issue_bus.sink),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .retire    (retire),
        .halted    (halted),
        .ret_valid (ret_valid),
        .ret_rd    (ret_rd),
        .ret_data  (ret_data)
    );

    rv_mini_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

endmodule

`default_nettype wire

// File: tb_rv_mini_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_mini_core import rv_mini_pkg::*; ();

    localparam int MEM_WORDS      = 64;
    localparam int TIMEOUT_CYCLES = MEM_WORDS * (4 + 5) + 100;

    logic                  clk;
    logic                  arst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [XLEN-1:0]       wb_adr;
    logic [XLEN-1:0]       wb_dat_r;
    logic                  wb_ack;
    logic                  ret_valid;
    logic [REG_ADDR_W-1:0] ret_rd;
    logic [XLEN-1:0]       ret_data;
    logic                  halted;

    logic [XLEN-1:0]       prog [MEM_WORDS];
    logic [REG_ADDR_W-1:0] exp_rd [MEM_WORDS];
    logic [XLEN-1:0]       exp_data [MEM_WORDS];
    integer                seed;
    int                    prog_len;
    int                    ret_count;
    int                    cycle_count;
    int                    mismatch_count = 0;
    int                    other_count = 0;
    logic                  busy = 1'b0;
    int                    ack_wait = 0;

    logic [XLEN-1:0]       exp_adr;
    logic [REG_ADDR_W-1:0] cur_rd;
    logic [XLEN-1:0]       cur_data;

    rv_mini_core uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .ret_valid (ret_valid),
        .ret_rd    (ret_rd),
        .ret_data  (ret_data),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [XLEN-1:0] encode_i(logic [11:0] imm, logic [4:0] rs1,
                                                 logic [2:0] f3, logic [4:0] rd,
                                                 logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [XLEN-1:0] encode_u(logic [19:0] imm, logic [4:0] rd,
                                                 logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    task automatic build_program();
        int         kind;
        logic [4:0] rd;
        logic [4:0] last_rd;
        logic [4:0] rs1;
        last_rd = 5'd1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = 32'hbad0_0000 + 32'(i); // Never fetched.
        end
        prog_len = 40 + $unsigned($random(seed)) % 24;
        for (int i = 0; i < prog_len - 1; i++) begin
            kind = $unsigned($random(seed)) % 8;
            rd   = 5'(1 + $unsigned($random(seed)) % 7); // Few registers, so chains form.
            rs1  = 5'($unsigned($random(seed)) % 8);
            case (kind)
                2: prog[i] = encode_i(12'($random(seed)), 5'd0, F3_ADDI, rd, OPC_OP_IMM);
                3: prog[i] = encode_u(20'($random(seed)), rd, OPC_LUI);
                4: prog[i] = encode_u(20'($random(seed)), rd, OPC_AUIPC);
                5: prog[i] = encode_i(12'($random(seed)), rs1, F3_ADDI, 5'd0, OPC_OP_IMM);
                6: begin
                    case ($unsigned($random(seed)) % 3)
                        0: prog[i] = encode_i(12'($random(seed)), rs1, 3'd0, rd, 7'b0110011);
                        1: prog[i] = encode_i(12'($random(seed)), rs1,
                                              3'(1 + $unsigned($random(seed)) % 7), rd,
                                              OPC_OP_IMM);
                        default: prog[i] = 32'h0000_0073; // ecall.
                    endcase
                end
                7: prog[i] = encode_i(12'($random(seed)), last_rd, F3_ADDI, rd, OPC_OP_IMM);
                default: prog[i] = encode_i(12'($random(seed)), rs1, F3_ADDI, rd, OPC_OP_IMM);
            endcase
            last_rd = rd;
        end
        prog[prog_len - 1] = 32'h0010_0073; // ebreak.
    endtask

    // Architectural model, run once over the straight-line program.
    task automatic predict_results();
        logic [XLEN-1:0] regs [32];
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] w;
        logic [4:0]      rd;
        logic [XLEN-1:0] val;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc = 32'h0;
        for (int i = 0; i < prog_len; i++) begin
            w   = prog[i];
            rd  = '0;
            val = '0;
            if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
                rd  = w[11:7];
                val = regs[w[19:15]] + {{20{w[31]}}, w[31:20]};
            end else if (w[6:0] == 7'b0110111) begin
                rd  = w[11:7];
                val = {w[31:12], 12'h000};
            end else if (w[6:0] == 7'b0010111) begin
                rd  = w[11:7];
                val = pc + {w[31:12], 12'h000};
            end
            if (rd != 5'd0) begin
                regs[rd] = val;
            end
            exp_rd[i]   = rd;
            exp_data[i] = val;
            pc          = pc + 32'd4;
        end
    endtask

    // Wishbone slave with a random ack delay of 0 to 3 cycles.
    always @(negedge clk) begin
        if (wb_ack) begin
            wb_ack = 1'b0;
            busy   = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy     = 1'b1;
                ack_wait = $unsigned($random(seed)) % 4;
            end
            if (ack_wait == 0) begin
                wb_ack   = 1'b1;
                wb_dat_r = prog[wb_adr[7:2]];
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ret_count <= 0;
        end else if (ret_valid) begin
            ret_count <= ret_count + 1;
        end
    end

    assign exp_adr  = 32'(ret_count) << 2;
    assign cur_rd   = exp_rd[ret_count];
    assign cur_data = exp_data[ret_count];

    a_adr: assert property (@(posedge clk) disable iff (!arst_n) wb_cyc |-> (wb_adr == exp_adr))
        else begin
            mismatch_count++;
            $display("Mismatch wb_adr: got %h expected %h", $sampled(wb_adr), $sampled(exp_adr));
        end

    a_adr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_stb && !wb_ack) |=> (wb_cyc && $stable(wb_adr)))
        else begin
            other_count++;
            $display("Fetch address changed or the read ended while it waited for ack");
        end

    a_stb: assert property (@(posedge clk) disable iff (!arst_n) wb_stb == wb_cyc)
        else begin
            other_count++;
            $display("wb_stb and wb_cyc did not move together");
        end

    a_drop: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_cyc && wb_ack) |=> !wb_cyc)
        else begin
            other_count++;
            $display("Bus cycle stayed open after the ack");
        end

    a_read_only: assert property (@(posedge clk) disable iff (!arst_n) wb_cyc |-> !wb_we)
        else begin
            other_count++;
            $display("Core raised wb_we on the instruction port");
        end

    a_rd: assert property (@(posedge clk) disable iff (!arst_n) ret_valid |-> (ret_rd == cur_rd))
        else begin
            mismatch_count++;
            $display("Mismatch ret_rd: got %h expected %h", $sampled(ret_rd), $sampled(cur_rd));
        end

    a_data: assert property (@(posedge clk) disable iff (!arst_n)
        (ret_valid && cur_rd != '0) |-> (ret_data == cur_data))
        else begin
            mismatch_count++;
            $display("Mismatch ret_data: got %h expected %h",
                     $sampled(ret_data), $sampled(cur_data));
        end

    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_cyc && wb_ack) |-> ##3 ret_valid)
        else begin
            other_count++;
            $display("ret_valid did not arrive 3 cycles after ack");
        end

    a_no_early: assert property (@(posedge clk) disable iff (!arst_n)
        ret_valid |-> $past(wb_cyc && wb_ack, 3))
        else begin
            other_count++;
            $display("ret_valid appeared without an ack 3 cycles before");
        end

    a_halt_point: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(halted) |-> (ret_count == prog_len - 1))
        else begin
            other_count++;
            $display("Core halted before reaching the ebreak");
        end

    a_halt_bus: assert property (@(posedge clk) disable iff (!arst_n) halted |-> !wb_cyc)
        else begin
            other_count++;
            $display("Halted core started another bus cycle");
        end

    a_halt_retire: assert property (@(posedge clk) disable iff (!arst_n) halted |=> !ret_valid)
        else begin
            other_count++;
            $display("Halted core retired another instruction");
        end

    initial begin
        seed        = 48854;
        arst_n      = 1'b0;
        wb_ack      = 1'b0;
        wb_dat_r    = '0;
        cycle_count = 0;
        build_program();
        predict_results();
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        while (!halted && cycle_count < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycle_count++;
        end
        if (!halted) begin
            other_count++;
            $display("Timeout: core did not halt within %0d cycles", TIMEOUT_CYCLES);
        end else begin
            repeat (10) @(negedge clk); // Watch the bus stay idle.
        end
        a_count: assert (ret_count == prog_len)
            else begin
                mismatch_count++;
                $display("Mismatch retire count: got %h expected %h", ret_count, prog_len);
            end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_mini_core.f
rv_mini_pkg.sv
rv_mini_stage_if.sv
rv_mini_regfile.sv
rv_mini_ifu.sv
rv_mini_idu.sv
rv_mini_exu.sv
rv_mini_core.sv
tb_rv_mini_core.sv

// File: Bender.yml
package:
  name: rv_mini_core

sources:
  - rv_mini_pkg.sv
  - rv_mini_stage_if.sv
  - rv_mini_regfile.sv
  - rv_mini_ifu.sv
  - rv_mini_idu.sv
  - rv_mini_exu.sv
  - rv_mini_core.sv
  - target: test
    files:
      - tb_rv_mini_core.sv
